//--- hw/fdsu_defs.svh
`ifndef FDSU_DEFS_SVH
`define FDSU_DEFS_SVH

// Exponent result carried between the EX stages
`define FDSU_EXPNT_W 10

// Floating register file index
`define FDSU_FREG_W 5

// IEEE rounding mode field
`define FDSU_RM_W 3

// SRT iteration counter
`define FDSU_CNT_W 5

// Rounds minus one for the single mantissa width
`define FDSU_CNT_INI 14

`endif

//--- hw/fdsu_pkg.sv
package fdsu_pkg;

  `include "fdsu_defs.svh"

  typedef logic [`FDSU_EXPNT_W-1:0] expnt_t;  // Exponent result
  typedef logic [`FDSU_FREG_W-1:0]  freg_t;   // Destination register index
  typedef logic [`FDSU_RM_W-1:0]    rm_t;     // Rounding mode
  typedef logic [`FDSU_CNT_W-1:0]   srt_cnt_t;  // Iteration count

  // Main sequencer
  typedef enum logic [2:0] {
    IDLE = 3'b000,  // No instruction in flight
    WFI2 = 3'b001,  // Wait for operand 1 after down-stall
    ITER = 3'b010,  // SRT iterations
    RND  = 3'b011,  // Rounding
    PACK = 3'b100,  // Result ready
    WFWB = 3'b101   // Waiting on write-back grant
  } fdsu_state_e;

  // Write-back tracker
  typedef enum logic [1:0] {
    WB_IDLE  = 2'b00,  // Nothing tracked
    WB_EX2   = 2'b10,  // Issued instruction left EX1
    WB_CMPLT = 2'b01   // Result waiting for grant
  } wb_state_e;

endpackage

//--- hw/fdsu_ctrl.sv
`timescale 1ns/10ps

module fdsu_ctrl (
  input  logic fdsu_clk,               // Unit clock
  input  logic cpurst_b,               // Async reset, active low
  input  logic ctrl_xx_ex1_inst_vld,   // EX1 instruction valid
  input  logic ctrl_fdsu_ex1_sel,      // EX1 instruction targets this unit
  input  logic ctrl_xx_ex1_stall,      // Pipeline holds EX1
  input  logic ex1_srt_skip,           // Result known without iteration
  input  logic ex1_op0_id,             // Operand 0 is denormal
  input  logic ex1_op1_id_vld,         // Operand 1 needs an extra cycle
  input  logic srt_last_round,         // Final SRT round this cycle
  input  logic frbus_fdsu_wb_grant,    // Result bus grant
  input  logic rtu_xx_ex1_cancel,      // Kill EX1
  input  logic rtu_xx_ex2_cancel,      // Kill EX2
  input  logic rtu_yy_xx_async_flush,  // Global flush
  output logic ex1_pipedown,           // Iteration start
  output logic ex2_pipedown,           // SRT done
  output logic ex3_pipedown,           // Rounding done
  output logic ex1_save_op0,           // Capture operand 0 exponent
  output logic ex1_op1_sel,            // Feed operand 1 in WFI2
  output logic fdsu_flush,             // Clears both machines
  output logic srt_itering,            // Sequencer in ITER
  output logic fdsu_fpu_ex1_cmplt,     // EX1 accepted by the unit
  output logic fdsu_fpu_ex1_stall,     // Hold EX1
  output logic fdsu_frbus_wb_vld,      // Result valid on the bus
  output logic fdsu_fpu_no_op          // Unit idle
);

  import fdsu_pkg::*;

  fdsu_state_e fdsu_cur_state;
  fdsu_state_e fdsu_next_state;
  wb_state_e   wb_cur_state;
  wb_state_e   wb_nxt_state;

  logic ex1_inst_vld;   // Valid and selected
  logic ex1_res_vld;    // Skip result, no iteration
  logic sm_start;       // Sequencer takes the EX1 instruction
  logic dn_stall;       // Start needs one WFI2 cycle
  logic iter_start;     // Counter load and EX1 pipedown
  logic srt_idle;       // Sequencer free this cycle
  logic sm_idle;
  logic sm_wfi2;
  logic sm_rnd;
  logic sm_cmplt;       // PACK or WFWB
  logic wb_sm_idle;
  logic wb_sm_ex2;
  logic wb_sm_cmplt;    // Tracker holds a result
  logic wb_idle;        // Tracker free this cycle
  logic result_vld;
  logic wb_retire;      // Result leaves on the bus
  logic busy;

  assign ex1_inst_vld = ctrl_xx_ex1_inst_vld && ctrl_fdsu_ex1_sel;
  assign ex1_res_vld  = ex1_inst_vld && ex1_srt_skip;

  assign sm_idle     = fdsu_cur_state == IDLE;
  assign sm_wfi2     = fdsu_cur_state == WFI2;
  assign srt_itering = fdsu_cur_state == ITER;
  assign sm_rnd      = fdsu_cur_state == RND;
  assign sm_cmplt    = (fdsu_cur_state == PACK) || (fdsu_cur_state == WFWB);

  assign wb_sm_idle  = wb_cur_state == WB_IDLE;
  assign wb_sm_ex2   = wb_cur_state == WB_EX2;
  assign wb_sm_cmplt = wb_sm_ex2 || (wb_cur_state == WB_CMPLT);

  assign result_vld = sm_cmplt && wb_sm_cmplt;  // Both machines agree on a result
  assign wb_retire  = result_vld && frbus_fdsu_wb_grant;

  assign srt_idle   = sm_idle || wb_retire;  // Back-to-back issue on grant
  assign sm_start   = ex1_inst_vld && srt_idle && !ex1_srt_skip;
  assign dn_stall   = sm_start && ex1_op1_id_vld;
  assign iter_start = sm_start && !dn_stall || sm_wfi2;

  assign wb_idle = wb_sm_idle || (wb_cur_state == WB_CMPLT) && wb_retire;

  always_ff @(posedge fdsu_clk or negedge cpurst_b) begin
    if (!cpurst_b)
      fdsu_cur_state <= IDLE;
    else if (fdsu_flush)
      fdsu_cur_state <= IDLE;  // Flush drops the instruction
    else
      fdsu_cur_state <= fdsu_next_state;
  end

  always_comb begin
    case (fdsu_cur_state)
      IDLE: begin
        if (sm_start)
          fdsu_next_state = dn_stall ? WFI2 : ITER;
        else
          fdsu_next_state = IDLE;
      end
      WFI2: fdsu_next_state = ITER;  // Operand 1 ready now
      ITER: fdsu_next_state = srt_last_round ? RND : ITER;
      RND:  fdsu_next_state = PACK;
      PACK, WFWB: begin
        if (!wb_retire)
          fdsu_next_state = WFWB;  // Hold under back-pressure
        else if (sm_start)
          fdsu_next_state = dn_stall ? WFI2 : ITER;  // Next one starts at once
        else
          fdsu_next_state = IDLE;
      end
      default: fdsu_next_state = IDLE;
    endcase
  end

  always_ff @(posedge fdsu_clk or negedge cpurst_b) begin
    if (!cpurst_b)
      wb_cur_state <= WB_IDLE;
    else if (fdsu_flush)
      wb_cur_state <= WB_IDLE;
    else
      wb_cur_state <= wb_nxt_state;
  end

  // Tracks whether the issued instruction left EX1 unstalled
  always_comb begin
    case (wb_cur_state)
      WB_IDLE: begin
        if (ex1_inst_vld && !(ctrl_xx_ex1_stall || ex1_res_vld || dn_stall))
          wb_nxt_state = WB_EX2;
        else
          wb_nxt_state = WB_IDLE;
      end
      WB_EX2, WB_CMPLT: begin
        if (!wb_retire)
          wb_nxt_state = WB_CMPLT;  // Result still owed
        else if (iter_start && !ctrl_xx_ex1_stall)
          wb_nxt_state = WB_EX2;  // Successor moves up
        else
          wb_nxt_state = WB_IDLE;
      end
      default: wb_nxt_state = WB_IDLE;
    endcase
  end

  assign fdsu_flush = rtu_xx_ex1_cancel && wb_idle  // Cancel only an untracked EX1
                   || rtu_xx_ex2_cancel && wb_sm_ex2
                   || rtu_yy_xx_async_flush;

  assign fdsu_fpu_ex1_stall = ex1_inst_vld && !(srt_idle || sm_wfi2) && !wb_idle
                           || ex1_inst_vld && dn_stall;  // Extra operand cycle

  assign busy = ex1_inst_vld || !sm_idle || !wb_sm_idle;

  assign ex1_pipedown       = iter_start;
  assign ex2_pipedown       = srt_last_round;  // Already qualified with ITER
  assign ex3_pipedown       = sm_rnd;
  assign ex1_save_op0       = sm_start && ex1_op0_id && ex1_op1_id_vld;
  assign ex1_op1_sel        = sm_wfi2;
  assign fdsu_fpu_ex1_cmplt = ex1_inst_vld;
  assign fdsu_frbus_wb_vld  = result_vld;
  assign fdsu_fpu_no_op     = !busy;

endmodule

//--- hw/fdsu_srt_cnt.sv
`timescale 1ns/10ps

`include "fdsu_defs.svh"

module fdsu_srt_cnt (
  input  logic fdsu_clk,             // Unit clock
  input  logic cpurst_b,             // Async reset, active low
  input  logic fdsu_flush,           // Drop iteration
  input  logic ex1_pipedown,         // Iteration start
  input  logic srt_itering,          // Sequencer in ITER
  input  logic ex2_of,               // Overflow known early
  input  logic ex2_uf_srt_skip,      // Underflow ends iteration
  input  logic srt_remainder_zero,   // Exact quotient reached
  output logic srt_last_round,       // Final round this cycle
  output logic ex2_srt_first_round,  // First round after start
  output logic srt_sm_on             // Iteration running
);

  import fdsu_pkg::*;

  srt_cnt_t srt_cnt;
  logic     srt_cnt_zero;
  logic     srt_early_end;  // Exception or exact result

  always_ff @(posedge fdsu_clk or negedge cpurst_b) begin
    if (!cpurst_b)
      srt_cnt <= '0;
    else if (fdsu_flush)
      srt_cnt <= '0;
    else if (ex1_pipedown)
      srt_cnt <= srt_cnt_t'(`FDSU_CNT_INI);  // Full round count
    else if (srt_itering)
      srt_cnt <= srt_cnt - srt_cnt_t'(1);
  end

  always_ff @(posedge fdsu_clk or negedge cpurst_b) begin
    if (!cpurst_b)
      ex2_srt_first_round <= 1'b0;
    else if (fdsu_flush)
      ex2_srt_first_round <= 1'b0;
    else
      ex2_srt_first_round <= ex1_pipedown;  // One cycle after each start
  end

  assign srt_cnt_zero  = ~|srt_cnt;
  assign srt_early_end = ex2_of || ex2_uf_srt_skip || srt_remainder_zero;

  assign srt_last_round = (srt_early_end || srt_cnt_zero) && srt_itering;
  assign srt_sm_on      = srt_itering;

endmodule

//--- hw/fdsu_stage_regs.sv
`timescale 1ns/10ps

module fdsu_stage_regs (
  input  logic            fdsu_clk,              // Unit clock
  input  logic            ex1_pipedown,          // Load EX1 bank
  input  logic            ex2_pipedown,          // Load EX2 bank
  input  fdsu_pkg::freg_t idu_fpu_ex1_dst_freg,  // Destination register
  input  logic            ex1_result_sign,       // Result sign
  input  logic            ex1_of_result_lfn,     // Overflow gives largest finite
  input  logic            ex1_div,               // Divide
  input  logic            ex1_sqrt,              // Square root
  input  fdsu_pkg::rm_t   ex1_rm,                // Rounding mode
  input  logic            ex2_result_inf,        // Infinite result
  input  logic            ex2_result_lfn,        // Largest finite result
  input  logic            ex2_of,                // Overflow
  input  logic            ex2_uf,                // Underflow
  input  logic            ex2_potnt_of,          // Overflow possible after round
  input  logic            ex2_potnt_uf,          // Underflow possible after round
  output fdsu_pkg::freg_t fdsu_yy_wb_freg,
  output logic            fdsu_yy_result_sign,
  output logic            fdsu_yy_of_rm_lfn,
  output logic            fdsu_yy_div,
  output logic            fdsu_yy_sqrt,
  output fdsu_pkg::rm_t   fdsu_yy_rm,
  output logic            fdsu_yy_result_inf,
  output logic            fdsu_yy_result_lfn,
  output logic            fdsu_yy_of,
  output logic            fdsu_yy_uf,
  output logic            fdsu_yy_potnt_of,
  output logic            fdsu_yy_potnt_uf
);

  // Instruction info, held for the whole iteration
  always_ff @(posedge fdsu_clk) begin
    if (ex1_pipedown) begin
      fdsu_yy_wb_freg     <= idu_fpu_ex1_dst_freg;
      fdsu_yy_result_sign <= ex1_result_sign;
      fdsu_yy_of_rm_lfn   <= ex1_of_result_lfn;
      fdsu_yy_div         <= ex1_div;
      fdsu_yy_sqrt        <= ex1_sqrt;
      fdsu_yy_rm          <= ex1_rm;
    end
  end

  // Exception info from the SRT stage
  always_ff @(posedge fdsu_clk) begin
    if (ex2_pipedown) begin
      fdsu_yy_result_inf <= ex2_result_inf;
      fdsu_yy_result_lfn <= ex2_result_lfn;
      fdsu_yy_of         <= ex2_of;
      fdsu_yy_uf         <= ex2_uf;
      fdsu_yy_potnt_of   <= ex2_potnt_of;
      fdsu_yy_potnt_uf   <= ex2_potnt_uf;
    end
  end

endmodule

//--- hw/fdsu_expnt_reg.sv
`timescale 1ns/10ps

module fdsu_expnt_reg (
  input  logic             fdsu_clk,                 // Unit clock
  input  logic             ex1_save_op0,             // Keep operand 0 exponent
  input  logic             ex1_pipedown,             // Iteration start
  input  logic             ex2_pipedown,             // SRT done
  input  logic             ex3_pipedown,             // Rounding done
  input  fdsu_pkg::expnt_t ex1_oper_id_expnt,        // Operand 0 exponent
  input  fdsu_pkg::expnt_t ex1_expnt_adder_op0,      // EX1 adder result
  input  fdsu_pkg::expnt_t ex2_srt_expnt_rst,        // EX2 exponent
  input  fdsu_pkg::expnt_t ex3_expnt_adjust_result,  // Adjusted after rounding
  input  logic             ex2_rslt_denorm,          // Denormal from EX2
  input  logic             ex3_rslt_denorm,          // Denormal from EX3
  output fdsu_pkg::expnt_t fdsu_yy_expnt_rst,        // Shared exponent
  output logic             fdsu_yy_rslt_denorm       // Result is denormal
);

  // One register serves all stages, save wins
  always_ff @(posedge fdsu_clk) begin
    if (ex1_save_op0)
      fdsu_yy_expnt_rst <= ex1_oper_id_expnt;
    else if (ex1_pipedown)
      fdsu_yy_expnt_rst <= ex1_expnt_adder_op0;
    else if (ex2_pipedown)
      fdsu_yy_expnt_rst <= ex2_srt_expnt_rst;
    else if (ex3_pipedown)
      fdsu_yy_expnt_rst <= ex3_expnt_adjust_result;  // Final exponent
  end

  always_ff @(posedge fdsu_clk) begin
    if (ex2_pipedown)
      fdsu_yy_rslt_denorm <= ex2_rslt_denorm;
    else if (ex3_pipedown)
      fdsu_yy_rslt_denorm <= ex3_rslt_denorm;  // Rounding may renormalize
  end

endmodule

//--- hw/fdsu_top.sv
`timescale 1ns/10ps

module fdsu_top (
  input  logic             fdsu_clk,
  input  logic             cpurst_b,
  input  logic             ctrl_xx_ex1_inst_vld,
  input  logic             ctrl_fdsu_ex1_sel,
  input  logic             ctrl_xx_ex1_stall,
  input  logic             ex1_srt_skip,
  input  logic             ex1_op0_id,
  input  logic             ex1_op1_id_vld,
  input  fdsu_pkg::freg_t  idu_fpu_ex1_dst_freg,
  input  logic             ex1_result_sign,
  input  logic             ex1_of_result_lfn,
  input  logic             ex1_div,
  input  logic             ex1_sqrt,
  input  fdsu_pkg::rm_t    ex1_rm,
  input  fdsu_pkg::expnt_t ex1_oper_id_expnt,
  input  fdsu_pkg::expnt_t ex1_expnt_adder_op0,
  input  logic             ex2_result_inf,
  input  logic             ex2_result_lfn,
  input  logic             ex2_of,
  input  logic             ex2_uf,
  input  logic             ex2_potnt_of,
  input  logic             ex2_potnt_uf,
  input  logic             ex2_uf_srt_skip,
  input  fdsu_pkg::expnt_t ex2_srt_expnt_rst,
  input  logic             ex2_rslt_denorm,
  input  fdsu_pkg::expnt_t ex3_expnt_adjust_result,
  input  logic             ex3_rslt_denorm,
  input  logic             srt_remainder_zero,
  input  logic             frbus_fdsu_wb_grant,
  input  logic             rtu_xx_ex1_cancel,
  input  logic             rtu_xx_ex2_cancel,
  input  logic             rtu_yy_xx_async_flush,
  output logic             ex1_pipedown,
  output logic             ex2_pipedown,
  output logic             ex3_pipedown,
  output logic             ex1_save_op0,
  output logic             ex1_op1_sel,
  output logic             ex2_srt_first_round,
  output logic             srt_sm_on,
  output logic             fdsu_fpu_ex1_cmplt,
  output logic             fdsu_fpu_ex1_stall,
  output logic             fdsu_frbus_wb_vld,
  output logic             fdsu_fpu_no_op,
  output fdsu_pkg::freg_t  fdsu_yy_wb_freg,
  output logic             fdsu_yy_result_sign,
  output logic             fdsu_yy_of_rm_lfn,
  output logic             fdsu_yy_div,
  output logic             fdsu_yy_sqrt,
  output fdsu_pkg::rm_t    fdsu_yy_rm,
  output logic             fdsu_yy_result_inf,
  output logic             fdsu_yy_result_lfn,
  output logic             fdsu_yy_of,
  output logic             fdsu_yy_uf,
  output logic             fdsu_yy_potnt_of,
  output logic             fdsu_yy_potnt_uf,
  output fdsu_pkg::expnt_t fdsu_yy_expnt_rst,
  output logic             fdsu_yy_rslt_denorm
);

  logic fdsu_flush;      // Control to counter
  logic srt_itering;     // Sequencer in ITER
  logic srt_last_round;  // Counter back to control

  fdsu_ctrl u_ctrl (
    .fdsu_clk              (fdsu_clk),
    .cpurst_b              (cpurst_b),
    .ctrl_xx_ex1_inst_vld  (ctrl_xx_ex1_inst_vld),
    .ctrl_fdsu_ex1_sel     (ctrl_fdsu_ex1_sel),
    .ctrl_xx_ex1_stall     (ctrl_xx_ex1_stall),
    .ex1_srt_skip          (ex1_srt_skip),
    .ex1_op0_id            (ex1_op0_id),
    .ex1_op1_id_vld        (ex1_op1_id_vld),
    .srt_last_round        (srt_last_round),
    .frbus_fdsu_wb_grant   (frbus_fdsu_wb_grant),
    .rtu_xx_ex1_cancel     (rtu_xx_ex1_cancel),
    .rtu_xx_ex2_cancel     (rtu_xx_ex2_cancel),
    .rtu_yy_xx_async_flush (rtu_yy_xx_async_flush),
    .ex1_pipedown          (ex1_pipedown),
    .ex2_pipedown          (ex2_pipedown),
    .ex3_pipedown          (ex3_pipedown),
    .ex1_save_op0          (ex1_save_op0),
    .ex1_op1_sel           (ex1_op1_sel),
    .fdsu_flush            (fdsu_flush),
    .srt_itering           (srt_itering),
    .fdsu_fpu_ex1_cmplt    (fdsu_fpu_ex1_cmplt),
    .fdsu_fpu_ex1_stall    (fdsu_fpu_ex1_stall),
    .fdsu_frbus_wb_vld     (fdsu_frbus_wb_vld),
    .fdsu_fpu_no_op        (fdsu_fpu_no_op)
  );

  fdsu_srt_cnt u_srt_cnt (
    .fdsu_clk            (fdsu_clk),
    .cpurst_b            (cpurst_b),
    .fdsu_flush          (fdsu_flush),
    .ex1_pipedown        (ex1_pipedown),
    .srt_itering         (srt_itering),
    .ex2_of              (ex2_of),
    .ex2_uf_srt_skip     (ex2_uf_srt_skip),
    .srt_remainder_zero  (srt_remainder_zero),
    .srt_last_round      (srt_last_round),
    .ex2_srt_first_round (ex2_srt_first_round),
    .srt_sm_on           (srt_sm_on)
  );

  fdsu_stage_regs u_stage_regs (
    .fdsu_clk             (fdsu_clk),
    .ex1_pipedown         (ex1_pipedown),
    .ex2_pipedown         (ex2_pipedown),
    .idu_fpu_ex1_dst_freg (idu_fpu_ex1_dst_freg),
    .ex1_result_sign      (ex1_result_sign),
    .ex1_of_result_lfn    (ex1_of_result_lfn),
    .ex1_div              (ex1_div),
    .ex1_sqrt             (ex1_sqrt),
    .ex1_rm               (ex1_rm),
    .ex2_result_inf       (ex2_result_inf),
    .ex2_result_lfn       (ex2_result_lfn),
    .ex2_of               (ex2_of),
    .ex2_uf               (ex2_uf),
    .ex2_potnt_of         (ex2_potnt_of),
    .ex2_potnt_uf         (ex2_potnt_uf),
    .fdsu_yy_wb_freg      (fdsu_yy_wb_freg),
    .fdsu_yy_result_sign  (fdsu_yy_result_sign),
    .fdsu_yy_of_rm_lfn    (fdsu_yy_of_rm_lfn),
    .fdsu_yy_div          (fdsu_yy_div),
    .fdsu_yy_sqrt         (fdsu_yy_sqrt),
    .fdsu_yy_rm           (fdsu_yy_rm),
    .fdsu_yy_result_inf   (fdsu_yy_result_inf),
    .fdsu_yy_result_lfn   (fdsu_yy_result_lfn),
    .fdsu_yy_of           (fdsu_yy_of),
    .fdsu_yy_uf           (fdsu_yy_uf),
    .fdsu_yy_potnt_of     (fdsu_yy_potnt_of),
    .fdsu_yy_potnt_uf     (fdsu_yy_potnt_uf)
  );

  fdsu_expnt_reg u_expnt_reg (
    .fdsu_clk                (fdsu_clk),
    .ex1_save_op0            (ex1_save_op0),
    .ex1_pipedown            (ex1_pipedown),
    .ex2_pipedown            (ex2_pipedown),
    .ex3_pipedown            (ex3_pipedown),
    .ex1_oper_id_expnt       (ex1_oper_id_expnt),
    .ex1_expnt_adder_op0     (ex1_expnt_adder_op0),
    .ex2_srt_expnt_rst       (ex2_srt_expnt_rst),
    .ex3_expnt_adjust_result (ex3_expnt_adjust_result),
    .ex2_rslt_denorm         (ex2_rslt_denorm),
    .ex3_rslt_denorm         (ex3_rslt_denorm),
    .fdsu_yy_expnt_rst       (fdsu_yy_expnt_rst),
    .fdsu_yy_rslt_denorm     (fdsu_yy_rslt_denorm)
  );

endmodule

//--- test/fdsu_clk_gen.sv
`timescale 1ns/10ps

module fdsu_clk_gen (
  output logic fdsu_clk,  // 20 ns period
  output logic cpurst_b   // Low for the first 10 cycles
);

  initial begin
    fdsu_clk = 1'b0;
    forever #10 fdsu_clk = ~fdsu_clk;
  end

  initial begin
    cpurst_b = 1'b0;
    repeat (10) @(posedge fdsu_clk);
    #2 cpurst_b = 1'b1;  // Release away from the edge
  end

endmodule

//--- test/fdsu_props.sv
`timescale 1ns/10ps

module fdsu_props (
  input logic                  fdsu_clk,
  input logic                  cpurst_b,
  input fdsu_pkg::fdsu_state_e fdsu_cur_state,
  input fdsu_pkg::wb_state_e   wb_cur_state,
  input logic                  fdsu_frbus_wb_vld,
  input logic                  frbus_fdsu_wb_grant,
  input logic                  fdsu_flush,
  input logic                  rtu_yy_xx_async_flush
);

  import fdsu_pkg::*;

  // Granted result leaves the bus at once
  a_retire_clear: assert property (@(posedge fdsu_clk) disable iff (!cpurst_b)
    fdsu_frbus_wb_vld && frbus_fdsu_wb_grant |=> !fdsu_frbus_wb_vld)
    else $error("write-back valid still high after grant");

  // Back-pressure keeps the result on the bus
  a_wb_hold: assert property (@(posedge fdsu_clk) disable iff (!cpurst_b)
    fdsu_frbus_wb_vld && !frbus_fdsu_wb_grant && !fdsu_flush |=> fdsu_frbus_wb_vld)
    else $error("write-back valid dropped without grant");

  // Flush clears both machines
  a_flush_idle: assert property (@(posedge fdsu_clk) disable iff (!cpurst_b)
    rtu_yy_xx_async_flush |=> (fdsu_cur_state == IDLE) && (wb_cur_state == WB_IDLE))
    else $error("machines not idle after async flush");

endmodule

bind fdsu_ctrl fdsu_props u_props (
  .fdsu_clk              (fdsu_clk),
  .cpurst_b              (cpurst_b),
  .fdsu_cur_state        (fdsu_cur_state),
  .wb_cur_state          (wb_cur_state),
  .fdsu_frbus_wb_vld     (fdsu_frbus_wb_vld),
  .frbus_fdsu_wb_grant   (frbus_fdsu_wb_grant),
  .fdsu_flush            (fdsu_flush),
  .rtu_yy_xx_async_flush (rtu_yy_xx_async_flush)
);

//--- test/fdsu_tb.sv
`timescale 1ns/10ps

module fdsu_tb;

  import fdsu_pkg::*;

  localparam int NUM_INST = 64;
  localparam int TIMEOUT  = NUM_INST * 40 + 20;  // Worst case per instruction plus reset

  logic fdsu_clk, cpurst_b;
  logic ctrl_xx_ex1_inst_vld, ctrl_fdsu_ex1_sel, ctrl_xx_ex1_stall;
  logic ex1_srt_skip, ex1_op0_id, ex1_op1_id_vld;
  freg_t idu_fpu_ex1_dst_freg;
  logic ex1_result_sign, ex1_of_result_lfn, ex1_div, ex1_sqrt;
  rm_t ex1_rm;
  expnt_t ex1_oper_id_expnt, ex1_expnt_adder_op0, ex2_srt_expnt_rst, ex3_expnt_adjust_result;
  logic ex2_result_inf, ex2_result_lfn, ex2_of, ex2_uf, ex2_potnt_of, ex2_potnt_uf;
  logic ex2_uf_srt_skip, ex2_rslt_denorm, ex3_rslt_denorm, srt_remainder_zero;
  logic frbus_fdsu_wb_grant, rtu_xx_ex1_cancel, rtu_xx_ex2_cancel, rtu_yy_xx_async_flush;
  logic ex1_pipedown, ex2_pipedown, ex3_pipedown, ex1_save_op0, ex1_op1_sel;
  logic ex2_srt_first_round, srt_sm_on, fdsu_fpu_ex1_cmplt, fdsu_fpu_ex1_stall;
  logic fdsu_frbus_wb_vld, fdsu_fpu_no_op;
  freg_t fdsu_yy_wb_freg;
  rm_t fdsu_yy_rm;
  expnt_t fdsu_yy_expnt_rst;
  logic fdsu_yy_result_sign, fdsu_yy_of_rm_lfn, fdsu_yy_div, fdsu_yy_sqrt;
  logic fdsu_yy_result_inf, fdsu_yy_result_lfn, fdsu_yy_of, fdsu_yy_uf;
  logic fdsu_yy_potnt_of, fdsu_yy_potnt_uf, fdsu_yy_rslt_denorm;

  integer seed = 32'h54f6;
  int     cycle_cnt = 0;

  fdsu_clk_gen u_clk_gen (.fdsu_clk(fdsu_clk), .cpurst_b(cpurst_b));

  fdsu_top DUT (.*);

  always @(posedge fdsu_clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT) begin
      $display("Timeout: run went past %0d cycles", TIMEOUT);
      $display("Test failed");
      $fatal(1, "timeout");
    end
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s expected=%0h got=%0h", $time, name, exp, got);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic drive_edge();  // Inputs change 2 ns after the edge
    @(posedge fdsu_clk);
    #2;
  endtask

  task automatic sample_point();
    @(negedge fdsu_clk);
  endtask

  task automatic randomize_fields();
    idu_fpu_ex1_dst_freg    = $random(seed);
    ex1_result_sign         = $random(seed);
    ex1_of_result_lfn       = $random(seed);
    ex1_div                 = $random(seed);
    ex1_sqrt                = $random(seed);
    ex1_rm                  = $random(seed);
    ex1_oper_id_expnt       = $random(seed);
    ex1_expnt_adder_op0     = $random(seed);
    ex2_srt_expnt_rst       = $random(seed);
    ex3_expnt_adjust_result = $random(seed);
    ex2_result_inf          = $random(seed);
    ex2_result_lfn          = $random(seed);
    ex2_uf                  = $random(seed);
    ex2_potnt_of            = $random(seed);
    ex2_potnt_uf            = $random(seed);
    ex2_rslt_denorm         = $random(seed);
    ex3_rslt_denorm         = $random(seed);
  endtask

  task automatic check_idle_after();
    check_val("srt_sm_on", srt_sm_on, 0);
    check_val("fdsu_frbus_wb_vld", fdsu_frbus_wb_vld, 0);
    check_val("fdsu_fpu_no_op", fdsu_fpu_no_op, 1);
  endtask

  // Full instruction with optional down-stall, early end and grant delay
  task automatic run_normal();
    logic [31:0] r;
    logic op1, op0, probe, exp_of;
    logic [3:0] term_at;
    logic [1:0] term_kind;
    int last, gdly;
    freg_t e_freg;
    rm_t e_rm;
    logic e_sign, e_div, e_sqrt, e_uf, e_denorm;
    logic e_of_lfn, e_inf, e_res_lfn, e_potnt_of, e_potnt_uf;
    expnt_t e_adder, e_oper, e_ex2, e_ex3;
    r = $random(seed);
    op1       = r[1:0] == 2'd0;
    op0       = r[2];
    term_at   = r[3] ? r[7:4] : 4'd0;  // Zero means full length
    term_kind = r[9:8];
    gdly      = r[11:10] + r[12];
    last      = (term_at != 0) ? term_at : 15;
    exp_of    = (term_at != 0) && (term_kind == 2'd1);
    drive_edge();
    randomize_fields();
    ctrl_xx_ex1_inst_vld = 1'b1;
    ex1_srt_skip         = 1'b0;
    ex1_op1_id_vld       = op1;
    ex1_op0_id           = op0;
    e_freg = idu_fpu_ex1_dst_freg;
    e_rm = ex1_rm;
    e_sign = ex1_result_sign;
    e_of_lfn = ex1_of_result_lfn;
    e_div = ex1_div;
    e_sqrt = ex1_sqrt;
    e_uf = ex2_uf;
    e_adder = ex1_expnt_adder_op0;
    e_oper = ex1_oper_id_expnt;
    e_ex2 = ex2_srt_expnt_rst;
    e_ex3 = ex3_expnt_adjust_result;
    e_denorm = ex3_rslt_denorm;
    sample_point();
    check_val("fdsu_fpu_ex1_cmplt", fdsu_fpu_ex1_cmplt, 1);
    check_val("fdsu_fpu_ex1_stall", fdsu_fpu_ex1_stall, op1);  // Down-stall only
    check_val("ex1_pipedown", ex1_pipedown, !op1);
    check_val("ex1_save_op0", ex1_save_op0, op0 && op1);
    if (op1) begin
      drive_edge();  // Pipeline re-presents the stalled instruction
      sample_point();
      check_val("ex1_op1_sel", ex1_op1_sel, 1);
      check_val("ex1_pipedown", ex1_pipedown, 1);
      check_val("fdsu_fpu_ex1_stall", fdsu_fpu_ex1_stall, 0);
      if (op0)
        check_val("fdsu_yy_expnt_rst", fdsu_yy_expnt_rst, e_oper);
    end
    drive_edge();
    ctrl_xx_ex1_inst_vld = 1'b0;
    ex1_op1_id_vld       = 1'b0;
    randomize_fields();  // EX1 banks must hold
    ex2_uf = e_uf;
    ex2_srt_expnt_rst = e_ex2;
    ex3_expnt_adjust_result = e_ex3;
    ex3_rslt_denorm = e_denorm;
    e_inf = ex2_result_inf;  // EX2 bank takes these at the last round
    e_res_lfn = ex2_result_lfn;
    e_potnt_of = ex2_potnt_of;
    e_potnt_uf = ex2_potnt_uf;
    for (int i = 1; i <= last; i++) begin
      if (i > 1)
        drive_edge();
      srt_remainder_zero = (i == term_at) && term_kind[0] == term_kind[1];
      ex2_of             = (i == term_at) && (term_kind == 2'd1);
      ex2_uf_srt_skip    = (i == term_at) && (term_kind == 2'd2);
      sample_point();
      check_val("srt_sm_on", srt_sm_on, 1);
      check_val("ex2_srt_first_round", ex2_srt_first_round, i == 1);
      check_val("ex2_pipedown", ex2_pipedown, i == last);
      check_val("fdsu_frbus_wb_vld", fdsu_frbus_wb_vld, 0);
      if (i == 1)
        check_val("fdsu_yy_expnt_rst", fdsu_yy_expnt_rst, e_adder);
    end
    drive_edge();
    srt_remainder_zero = 1'b0;
    ex2_of             = 1'b0;
    ex2_uf_srt_skip    = 1'b0;
    sample_point();  // RND
    check_val("ex3_pipedown", ex3_pipedown, 1);
    check_val("srt_sm_on", srt_sm_on, 0);
    check_val("fdsu_frbus_wb_vld", fdsu_frbus_wb_vld, 0);
    check_val("fdsu_yy_expnt_rst", fdsu_yy_expnt_rst, e_ex2);
    check_val("fdsu_yy_of", fdsu_yy_of, exp_of);
    check_val("fdsu_yy_uf", fdsu_yy_uf, e_uf);
    check_val("fdsu_yy_result_inf", fdsu_yy_result_inf, e_inf);
    check_val("fdsu_yy_result_lfn", fdsu_yy_result_lfn, e_res_lfn);
    check_val("fdsu_yy_potnt_of", fdsu_yy_potnt_of, e_potnt_of);
    check_val("fdsu_yy_potnt_uf", fdsu_yy_potnt_uf, e_potnt_uf);
    for (int k = 0; k <= gdly; k++) begin
      drive_edge();
      probe = (k < gdly) && ($random(seed) & 1);
      frbus_fdsu_wb_grant  = (k == gdly);
      ctrl_xx_ex1_inst_vld = probe;  // New issue while result is owed
      sample_point();
      check_val("fdsu_frbus_wb_vld", fdsu_frbus_wb_vld, 1);
      check_val("fdsu_fpu_ex1_stall", fdsu_fpu_ex1_stall, probe);
      check_val("fdsu_fpu_no_op", fdsu_fpu_no_op, 0);
    end
    check_val("fdsu_yy_wb_freg", fdsu_yy_wb_freg, e_freg);
    check_val("fdsu_yy_rm", fdsu_yy_rm, e_rm);
    check_val("fdsu_yy_result_sign", fdsu_yy_result_sign, e_sign);
    check_val("fdsu_yy_of_rm_lfn", fdsu_yy_of_rm_lfn, e_of_lfn);
    check_val("fdsu_yy_div", fdsu_yy_div, e_div);
    check_val("fdsu_yy_sqrt", fdsu_yy_sqrt, e_sqrt);
    check_val("fdsu_yy_expnt_rst", fdsu_yy_expnt_rst, e_ex3);
    check_val("fdsu_yy_rslt_denorm", fdsu_yy_rslt_denorm, e_denorm);
    drive_edge();
    frbus_fdsu_wb_grant = 1'b0;
    sample_point();
    check_idle_after();
  endtask

  // Flush in the middle of the iteration
  task automatic run_flush();
    int at;
    at = 1 + ($unsigned($random(seed)) % 12);
    drive_edge();
    randomize_fields();
    ctrl_xx_ex1_inst_vld = 1'b1;
    ex1_srt_skip = 1'b0;
    ex1_op1_id_vld = 1'b0;
    repeat (at) drive_edge();
    ctrl_xx_ex1_inst_vld = 1'b0;
    rtu_yy_xx_async_flush = 1'b1;
    drive_edge();
    rtu_yy_xx_async_flush = 1'b0;
    for (int i = 0; i < 3; i++) begin
      sample_point();
      check_idle_after();
      drive_edge();
    end
  endtask

  task automatic run_cancel();  // EX1 cancel with tracker idle
    drive_edge();
    randomize_fields();
    ctrl_xx_ex1_inst_vld = 1'b1;
    ex1_srt_skip = 1'b0;
    ex1_op1_id_vld = 1'b0;
    rtu_xx_ex1_cancel = 1'b1;
    drive_edge();
    ctrl_xx_ex1_inst_vld = 1'b0;
    rtu_xx_ex1_cancel = 1'b0;
    sample_point();
    check_idle_after();
  endtask

  task automatic run_skip();
    drive_edge();
    randomize_fields();
    ctrl_xx_ex1_inst_vld = 1'b1;
    ex1_srt_skip = 1'b1;
    sample_point();
    check_val("ex1_pipedown", ex1_pipedown, 0);
    check_val("fdsu_fpu_ex1_stall", fdsu_fpu_ex1_stall, 0);
    drive_edge();
    ctrl_xx_ex1_inst_vld = 1'b0;
    ex1_srt_skip = 1'b0;
    sample_point();
    check_idle_after();
  endtask

  initial begin
    ctrl_xx_ex1_inst_vld  = 1'b0;
    ctrl_fdsu_ex1_sel     = 1'b1;
    ctrl_xx_ex1_stall     = 1'b0;
    ex1_srt_skip          = 1'b0;
    ex1_op0_id            = 1'b0;
    ex1_op1_id_vld        = 1'b0;
    ex2_of                = 1'b0;
    ex2_uf_srt_skip       = 1'b0;
    srt_remainder_zero    = 1'b0;
    frbus_fdsu_wb_grant   = 1'b0;
    rtu_xx_ex1_cancel     = 1'b0;
    rtu_xx_ex2_cancel     = 1'b0;
    rtu_yy_xx_async_flush = 1'b0;
    randomize_fields();
    wait (cpurst_b === 1'b1);
    sample_point();
    check_idle_after();
    check_val("ex2_srt_first_round", ex2_srt_first_round, 0);
    check_val("fdsu_fpu_ex1_stall", fdsu_fpu_ex1_stall, 0);
    for (int n = 0; n < NUM_INST; n++) begin
      case ($unsigned($random(seed)) % 8)
        0: run_skip();
        1: run_flush();
        2: run_cancel();
        default: run_normal();
      endcase
    end
    $display("Test passed");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+hw
hw/fdsu_pkg.sv
hw/fdsu_ctrl.sv
hw/fdsu_srt_cnt.sv
hw/fdsu_stage_regs.sv
hw/fdsu_expnt_reg.sv
hw/fdsu_top.sv
test/fdsu_clk_gen.sv
test/fdsu_props.sv
test/fdsu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= fdsu_tb
SEED      ?= 1
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

VFLAGS ?= --timing --assert -f $(FILELIST) --top-module $(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED)

clean:
	rm -rf $(OBJ_DIR)
